// File: include/cpu_pipe_consts.svh
`ifndef CPU_PIPE_CONSTS_SVH
`define CPU_PIPE_CONSTS_SVH

// Instruction word width
`define CPU_DATA_BITS 16

// Byte address width, word address drops bit 0
`define CPU_ADDR_BITS 16

// Register tag carried with each slot for hazard compare
`define CPU_HAZ_REG_BITS 7

// Word address fetched first after reset
`define CPU_RESET_PC 0

`endif

// File: source/cpu_pipe_pkg.sv
`include "cpu_pipe_consts.svh"

package cpu_pipe_pkg;

	// One instruction as fetched
	typedef logic [`CPU_DATA_BITS - 1 : 0] ins_word_t;

	// Instruction word address, byte address without bit 0
	typedef logic [`CPU_ADDR_BITS - 2 : 0] word_addr_t;

	// Destination register tag travelling with the slot
	typedef logic [`CPU_HAZ_REG_BITS - 1 : 0] haz_reg_t;

	// Sequencer states
	// Stall states are entered at stall1, stall2 or stall3
	// depending on how many bubbles the hazard needs
	typedef enum logic [2:0] {
		st_reset,
		st_refill,
		st_execute,
		st_stall1,
		st_stall2,
		st_stall3
	} seq_state_t;

endpackage

// File: source/pipeline_sequencer.sv
`timescale 1ns/1ns

module pipeline_sequencer (
	input  logic CLK,
	input  logic RSTb,

	// Branch from execute stage
	input  logic load_pc_request,

	// Hazards of slot 0 against slots 1, 2 and 3
	input  logic hazard_1,
	input  logic hazard_2,
	input  logic hazard_3,

	output logic fetch_en,
	output logic pc_load,
	output logic front_flush,
	output logic decode_hold,
	output logic exec_bubble,
	output logic stall_entry
);

	cpu_pipe_pkg::seq_state_t state_r;
	cpu_pipe_pkg::seq_state_t state_nxt;

	logic in_stall;
	logic branch_ok;
	logic any_hazard;

	assign in_stall = (state_r == cpu_pipe_pkg::st_stall1) ||
		(state_r == cpu_pipe_pkg::st_stall2) ||
		(state_r == cpu_pipe_pkg::st_stall3);

	// Branches are taken in execute and in every stall state
	// A branch sitting in slot 2 during stall1 must not be lost
	assign branch_ok = load_pc_request &&
		((state_r == cpu_pipe_pkg::st_execute) || in_stall);

	assign any_hazard = hazard_1 || hazard_2 || hazard_3;

	// Hazard cycle, the branch has priority over it
	assign stall_entry = (state_r == cpu_pipe_pkg::st_execute) &&
		!load_pc_request && any_hazard;

	// Only execute requests instructions
	assign fetch_en = (state_r == cpu_pipe_pkg::st_execute);
	assign pc_load = branch_ok;

	// Kill younger words on a branch, and keep the front empty while refilling
	assign front_flush = branch_ok ||
		(state_r == cpu_pipe_pkg::st_reset) ||
		(state_r == cpu_pipe_pkg::st_refill);

	// Decode keeps its word, execute sees bubbles
	assign decode_hold = in_stall;
	assign exec_bubble = in_stall;

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			cpu_pipe_pkg::st_reset:
				state_nxt = cpu_pipe_pkg::st_refill;
			cpu_pipe_pkg::st_refill:
				state_nxt = cpu_pipe_pkg::st_execute;
			cpu_pipe_pkg::st_execute: begin
				// Priority is branch, then nearest hazard first
				if (load_pc_request)
					state_nxt = cpu_pipe_pkg::st_refill;
				else if (hazard_1)
					state_nxt = cpu_pipe_pkg::st_stall1;
				else if (hazard_2)
					state_nxt = cpu_pipe_pkg::st_stall2;
				else if (hazard_3)
					state_nxt = cpu_pipe_pkg::st_stall3;
			end
			cpu_pipe_pkg::st_stall1:
				state_nxt = load_pc_request ? cpu_pipe_pkg::st_refill : cpu_pipe_pkg::st_stall2;
			cpu_pipe_pkg::st_stall2:
				state_nxt = load_pc_request ? cpu_pipe_pkg::st_refill : cpu_pipe_pkg::st_stall3;
			cpu_pipe_pkg::st_stall3:
				state_nxt = load_pc_request ? cpu_pipe_pkg::st_refill : cpu_pipe_pkg::st_execute;
			default:
				state_nxt = cpu_pipe_pkg::st_reset;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state_r <= cpu_pipe_pkg::st_reset;
		else
			state_r <= state_nxt;
	end

	// Stall chain only moves forward, or leaves through a branch
	a_stall1_next: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == cpu_pipe_pkg::st_stall1) |=>
		(state_r inside {cpu_pipe_pkg::st_stall2, cpu_pipe_pkg::st_refill}));

	a_stall2_next: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == cpu_pipe_pkg::st_stall2) |=>
		(state_r inside {cpu_pipe_pkg::st_stall3, cpu_pipe_pkg::st_refill}));

	a_stall3_next: assert property (@(posedge CLK) disable iff (!RSTb)
		(state_r == cpu_pipe_pkg::st_stall3) |=>
		(state_r inside {cpu_pipe_pkg::st_execute, cpu_pipe_pkg::st_refill}));

	// No fetch in the cycle after a hazard or a branch is taken
	a_no_fetch_after: assert property (@(posedge CLK) disable iff (!RSTb)
		(stall_entry || pc_load) |=> !fetch_en);

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ns

`include "cpu_pipe_consts.svh"

module fetch_stage (
	input  logic CLK,
	input  logic RSTb,

	// Controls from the sequencer
	input  logic fetch_en,
	input  logic pc_load,
	input  logic front_flush,
	input  logic stall_entry,

	// Branch target, byte address
	input  logic [`CPU_ADDR_BITS - 1 : 0] load_pc_address,

	// Wishbone classic read master
	output logic wb_cyc,
	output logic wb_stb,
	output cpu_pipe_pkg::word_addr_t wb_adr,
	input  cpu_pipe_pkg::ins_word_t wb_dat,
	input  logic wb_ack,

	// Slot 0
	output cpu_pipe_pkg::ins_word_t slot0_ins,
	output cpu_pipe_pkg::word_addr_t slot0_pc,
	output logic slot0_nop
);

	cpu_pipe_pkg::word_addr_t pc_r;

	logic accept;
	logic take_word;

	// Single read cycle per word, cyc follows stb
	assign wb_stb = fetch_en;
	assign wb_cyc = fetch_en;

	// Address comes straight from the PC, so it holds while ack is low
	assign wb_adr = pc_r;

	assign accept = wb_stb && wb_ack;

	// Word acknowledged in a hazard or branch cycle is dropped
	// and fetched again later from the same PC
	assign take_word = accept && !stall_entry && !front_flush;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			pc_r <= cpu_pipe_pkg::word_addr_t'(`CPU_RESET_PC);
		else if (pc_load)
			pc_r <= load_pc_address[`CPU_ADDR_BITS - 1 : 1];
		else if (take_word)
			pc_r <= pc_r + cpu_pipe_pkg::word_addr_t'(1);
	end

	// Payload follows the bus every cycle
	always_ff @(posedge CLK) begin
		slot0_ins <= wb_dat;
		slot0_pc <= wb_adr;
	end

	// Bubble unless a word is really taken
	always_ff @(posedge CLK) begin
		if (!RSTb)
			slot0_nop <= 1'b1;
		else
			slot0_nop <= !take_word;
	end

	// Address is held through wait states unless the request is withdrawn
	a_wb_adr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && !wb_ack) |=> (!wb_stb || $stable(wb_adr)));

endmodule

// File: source/decode_slot.sv
`timescale 1ns/1ns

module decode_slot (
	input  logic CLK,

	// Controls from the sequencer
	input  logic decode_hold,
	input  logic front_flush,

	// Slot 0
	input  cpu_pipe_pkg::ins_word_t slot0_ins,
	input  cpu_pipe_pkg::word_addr_t slot0_pc,
	input  logic slot0_nop,

	// Tag computed outside for the word now in slot 0
	input  cpu_pipe_pkg::haz_reg_t hazard_reg0,

	// Slot 1
	output cpu_pipe_pkg::ins_word_t slot1_ins,
	output cpu_pipe_pkg::word_addr_t slot1_pc,
	output logic slot1_nop,
	output cpu_pipe_pkg::haz_reg_t hazard_reg1
);

	// Word, address and tag advance together
	// During a stall all three stay put so the hazard can be re-checked
	always_ff @(posedge CLK) begin
		if (!decode_hold) begin
			slot1_ins <= slot0_ins;
			slot1_pc <= slot0_pc;
			hazard_reg1 <= hazard_reg0;
		end
	end

	// Nop flag
	// A flush always wins, even over a hold
	// On hold without flush the flag is kept
	always_ff @(posedge CLK) begin
		if (front_flush)
			slot1_nop <= 1'b1;
		else if (!decode_hold)
			slot1_nop <= slot0_nop;
	end

endmodule

// File: source/back_slots.sv
`timescale 1ns/1ns

`include "cpu_pipe_consts.svh"

module back_slots (
	input  logic CLK,

	// Controls from the sequencer
	input  logic exec_bubble,
	input  logic front_flush,

	// Slot 1
	input  cpu_pipe_pkg::ins_word_t slot1_ins,
	input  cpu_pipe_pkg::word_addr_t slot1_pc,
	input  logic slot1_nop,
	input  cpu_pipe_pkg::haz_reg_t hazard_reg1,

	// Instruction in execute, memory and writeback
	output cpu_pipe_pkg::ins_word_t pipeline_stage_2,
	output cpu_pipe_pkg::ins_word_t pipeline_stage_3,
	output cpu_pipe_pkg::ins_word_t pipeline_stage_4,

	output logic nop_stage_2,
	output logic nop_stage_4,

	// Writeback address as a byte address
	output logic [`CPU_ADDR_BITS - 1 : 0] pc_stage_4,

	// Exported tags for the outside hazard logic
	output cpu_pipe_pkg::haz_reg_t hazard_reg2,
	output cpu_pipe_pkg::haz_reg_t hazard_reg3
);

	cpu_pipe_pkg::word_addr_t pc2_r;
	cpu_pipe_pkg::word_addr_t pc3_r;
	cpu_pipe_pkg::word_addr_t pc4_r;

	logic nop3_r;

	// Execute slot
	// Bubble while decode is stalled, kill on branch or refill
	always_ff @(posedge CLK) begin
		pipeline_stage_2 <= slot1_ins;
		pc2_r <= slot1_pc;
		hazard_reg2 <= hazard_reg1;
		nop_stage_2 <= slot1_nop || exec_bubble || front_flush;
	end

	// Memory slot, plain shift
	always_ff @(posedge CLK) begin
		pipeline_stage_3 <= pipeline_stage_2;
		pc3_r <= pc2_r;
		hazard_reg3 <= hazard_reg2;
		nop3_r <= nop_stage_2;
	end

	// Writeback slot, tag no longer needed here
	always_ff @(posedge CLK) begin
		pipeline_stage_4 <= pipeline_stage_3;
		pc4_r <= pc3_r;
		nop_stage_4 <= nop3_r;
	end

	// Words are 2-byte aligned
	assign pc_stage_4 = {pc4_r, 1'b0};

endmodule

// File: source/cpu_pipeline_top.sv
`timescale 1ns/1ns

`include "cpu_pipe_consts.svh"

module cpu_pipeline_top (
	input  logic CLK,
	input  logic RSTb,

	// Wishbone instruction fetch
	output logic wb_cyc,
	output logic wb_stb,
	output cpu_pipe_pkg::word_addr_t wb_adr,
	input  cpu_pipe_pkg::ins_word_t wb_dat,
	input  logic wb_ack,

	// Branch request from execute
	input  logic load_pc_request,
	input  logic [`CPU_ADDR_BITS - 1 : 0] load_pc_address,

	// Hazard detection lives outside
	input  logic hazard_1,
	input  logic hazard_2,
	input  logic hazard_3,
	input  cpu_pipe_pkg::haz_reg_t hazard_reg0,
	output cpu_pipe_pkg::haz_reg_t hazard_reg1,
	output cpu_pipe_pkg::haz_reg_t hazard_reg2,
	output cpu_pipe_pkg::haz_reg_t hazard_reg3,

	// Slot contents for the datapath
	output cpu_pipe_pkg::ins_word_t pipeline_stage_2,
	output cpu_pipe_pkg::ins_word_t pipeline_stage_3,
	output cpu_pipe_pkg::ins_word_t pipeline_stage_4,
	output logic [`CPU_ADDR_BITS - 1 : 0] pc_stage_4,
	output logic nop_stage_2,
	output logic nop_stage_4
);

	// Sequencer controls
	logic fetch_en;
	logic pc_load;
	logic front_flush;
	logic decode_hold;
	logic exec_bubble;
	logic stall_entry;

	// Slot 0 and slot 1
	cpu_pipe_pkg::ins_word_t slot0_ins;
	cpu_pipe_pkg::word_addr_t slot0_pc;
	logic slot0_nop;
	cpu_pipe_pkg::ins_word_t slot1_ins;
	cpu_pipe_pkg::word_addr_t slot1_pc;
	logic slot1_nop;

	pipeline_sequencer seq_i (
		.CLK(CLK), .RSTb(RSTb), .load_pc_request(load_pc_request),
		.hazard_1(hazard_1), .hazard_2(hazard_2), .hazard_3(hazard_3),
		.fetch_en(fetch_en), .pc_load(pc_load), .front_flush(front_flush),
		.decode_hold(decode_hold), .exec_bubble(exec_bubble), .stall_entry(stall_entry)
	);

	fetch_stage fetch_i (
		.CLK(CLK), .RSTb(RSTb), .fetch_en(fetch_en), .pc_load(pc_load),
		.front_flush(front_flush), .stall_entry(stall_entry),
		.load_pc_address(load_pc_address),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack),
		.slot0_ins(slot0_ins), .slot0_pc(slot0_pc), .slot0_nop(slot0_nop)
	);

	decode_slot decode_i (
		.CLK(CLK), .decode_hold(decode_hold), .front_flush(front_flush),
		.slot0_ins(slot0_ins), .slot0_pc(slot0_pc), .slot0_nop(slot0_nop),
		.hazard_reg0(hazard_reg0),
		.slot1_ins(slot1_ins), .slot1_pc(slot1_pc), .slot1_nop(slot1_nop),
		.hazard_reg1(hazard_reg1)
	);

	back_slots back_i (
		.CLK(CLK), .exec_bubble(exec_bubble), .front_flush(front_flush),
		.slot1_ins(slot1_ins), .slot1_pc(slot1_pc), .slot1_nop(slot1_nop),
		.hazard_reg1(hazard_reg1),
		.pipeline_stage_2(pipeline_stage_2), .pipeline_stage_3(pipeline_stage_3),
		.pipeline_stage_4(pipeline_stage_4),
		.nop_stage_2(nop_stage_2), .nop_stage_4(nop_stage_4), .pc_stage_4(pc_stage_4),
		.hazard_reg2(hazard_reg2), .hazard_reg3(hazard_reg3)
	);

endmodule

// File: verif/tb_wb_program_memory.sv
`timescale 1ns/1ns

`include "cpu_pipe_consts.svh"

module tb_wb_program_memory #(
	parameter logic [`CPU_DATA_BITS - 1 : 0] data_mul = 16'h9e37,
	parameter logic [`CPU_DATA_BITS - 1 : 0] data_add = 16'h5a5a
) (
	input  logic CLK,
	input  logic RSTb,

	// Wishbone classic read slave
	input  logic wb_cyc,
	input  logic wb_stb,
	input  cpu_pipe_pkg::word_addr_t wb_adr,
	output cpu_pipe_pkg::ins_word_t wb_dat,
	output logic wb_ack,

	// Wait states for the next request, from the testbench LFSR
	input  logic [1:0] ack_delay
);

	logic [1:0] wait_cnt;
	logic [1:0] delay_r;
	logic [1:0] cur_delay;

	// Every address holds a word computed from the address itself
	assign wb_dat = cpu_pipe_pkg::ins_word_t'({1'b0, wb_adr} * data_mul + data_add);

	// First cycle of a request uses the fresh delay, later ones the latched copy
	assign cur_delay = (wait_cnt == 2'd0) ? ack_delay : delay_r;
	assign wb_ack = wb_cyc && wb_stb && (wait_cnt >= cur_delay);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wait_cnt <= 2'd0;
			delay_r <= 2'd0;
		end else begin
			if (wait_cnt == 2'd0)
				delay_r <= ack_delay;
			// Restart on a finished or withdrawn request
			if (!wb_stb || wb_ack)
				wait_cnt <= 2'd0;
			else
				wait_cnt <= wait_cnt + 2'd1;
		end
	end

endmodule

// File: verif/tb_cpu_pipeline.sv
`timescale 1ns/1ns

`include "cpu_pipe_consts.svh"

module tb_cpu_pipeline;

	localparam int clk_period = 20;
	localparam int run_cycles = 2500;
	localparam int watchdog_ns = 3000 * clk_period + 1000;
	localparam logic [15:0] data_mul = 16'h9e37;
	localparam logic [15:0] data_add = 16'h5a5a;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic CLK;
	logic RSTb;
	logic wb_cyc;
	logic wb_stb;
	cpu_pipe_pkg::word_addr_t wb_adr;
	cpu_pipe_pkg::ins_word_t wb_dat;
	logic wb_ack;
	logic [1:0] ack_delay;
	logic load_pc_request;
	logic [`CPU_ADDR_BITS - 1 : 0] load_pc_address;
	logic hazard_1;
	logic hazard_2;
	logic hazard_3;
	cpu_pipe_pkg::haz_reg_t hazard_reg0;
	cpu_pipe_pkg::haz_reg_t hazard_reg1;
	cpu_pipe_pkg::haz_reg_t hazard_reg2;
	cpu_pipe_pkg::haz_reg_t hazard_reg3;
	cpu_pipe_pkg::ins_word_t pipeline_stage_2;
	cpu_pipe_pkg::ins_word_t pipeline_stage_3;
	cpu_pipe_pkg::ins_word_t pipeline_stage_4;
	logic [`CPU_ADDR_BITS - 1 : 0] pc_stage_4;
	logic nop_stage_2;
	logic nop_stage_4;

	// Reference model state
	logic [31:0] lfsr_state;
	int cyc;
	int post_cnt;
	int retired;
	cpu_pipe_pkg::word_addr_t exp_pc;
	cpu_pipe_pkg::haz_reg_t held_tag;
	int branch_when_q[$];
	cpu_pipe_pkg::word_addr_t branch_target_q[$];
	logic branch_hit;

	cpu_pipeline_top dut_i (
		.CLK(CLK), .RSTb(RSTb),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack),
		.load_pc_request(load_pc_request), .load_pc_address(load_pc_address),
		.hazard_1(hazard_1), .hazard_2(hazard_2), .hazard_3(hazard_3),
		.hazard_reg0(hazard_reg0), .hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2), .hazard_reg3(hazard_reg3),
		.pipeline_stage_2(pipeline_stage_2), .pipeline_stage_3(pipeline_stage_3),
		.pipeline_stage_4(pipeline_stage_4), .pc_stage_4(pc_stage_4),
		.nop_stage_2(nop_stage_2), .nop_stage_4(nop_stage_4)
	);

	tb_wb_program_memory #(.data_mul(data_mul), .data_add(data_add)) mem_i (
		.CLK(CLK), .RSTb(RSTb),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack),
		.ack_delay(ack_delay)
	);

	// Word that memory must hold at a word address
	function automatic cpu_pipe_pkg::ins_word_t expected_word(input cpu_pipe_pkg::word_addr_t a);
		expected_word = cpu_pipe_pkg::ins_word_t'({1'b0, a} * data_mul + data_add);
	endfunction

	// One step of the Galois LFSR
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = (s >> 1) ^ (s[0] ? lfsr_taps : 32'h0);
	endfunction

	// Take n random bits, one LFSR step per bit
	task automatic random_bits(input int n, output logic [31:0] val);
		val = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic abort_with_reason(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	initial begin
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	// Watchdog sized from the run length plus margin
	initial begin
		#(watchdog_ns);
		abort_with_reason("Timeout: the test did not reach its end in time");
	end

	// Cycle counters, total and since reset release
	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (!RSTb)
			post_cnt <= 0;
		else
			post_cnt <= post_cnt + 1;
	end

	// Branch recorded when accepted, the branching word reaches stage 4 two edges later
	assign branch_hit = (branch_when_q.size() != 0) && (branch_when_q[0] == cyc);

	// Scoreboard for the retired address sequence
	always @(posedge CLK) begin
		if (!RSTb) begin
			exp_pc <= cpu_pipe_pkg::word_addr_t'(`CPU_RESET_PC);
			retired <= 0;
		end else begin
			if (load_pc_request && !nop_stage_2) begin
				branch_when_q.push_back(cyc + 2);
				branch_target_q.push_back(load_pc_address[`CPU_ADDR_BITS - 1 : 1]);
			end
			if (!nop_stage_4 && post_cnt >= 1) begin
				retired <= retired + 1;
				if (branch_hit)
					exp_pc <= branch_target_q[0];
				else
					exp_pc <= pc_stage_4[`CPU_ADDR_BITS - 1 : 1] + 1'b1;
			end
			if (branch_hit) begin
				branch_when_q.pop_front();
				branch_target_q.pop_front();
			end
		end
	end

	// Tag that decode must keep through a stall
	always_ff @(posedge CLK) begin
		if (wb_stb && (hazard_1 || hazard_2 || hazard_3) && !load_pc_request)
			held_tag <= hazard_reg0;
	end

	// Reset and refill keep the bus idle and the slots empty
	// Slot 2 is flushed by the second reset edge
	a_reset_idle: assert property (@(posedge CLK)
		(cyc >= 2 && (!RSTb || post_cnt < 2)) |-> (!wb_stb && nop_stage_2))
		else report_mismatch("bus active or slot 2 valid during reset");

	a_reset_wb_empty: assert property (@(posedge CLK)
		(RSTb && post_cnt >= 1 && post_cnt <= 2) |-> nop_stage_4)
		else report_mismatch("slot 4 valid right after reset");

	// Classic read cycle, cyc and stb move together
	a_cyc_stb: assert property (@(posedge CLK) disable iff (!RSTb)
		wb_cyc == wb_stb)
		else report_mismatch("wb_cyc differs from wb_stb");

	// Address held during a wait state
	a_adr_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && !wb_ack && !load_pc_request) |=> $stable(wb_adr))
		else report_mismatch("wb_adr changed during a wait state");

	// Next address after a clean accept
	a_adr_step: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && wb_ack && !load_pc_request && !hazard_1 && !hazard_2 && !hazard_3)
		|=> (wb_adr == cpu_pipe_pkg::word_addr_t'($past(wb_adr) + 1'b1)))
		else report_mismatch("wb_adr did not advance after an accepted word");

	// Retired word matches its address
	a_word_data: assert property (@(posedge CLK) disable iff (!RSTb)
		(post_cnt >= 1 && !nop_stage_4) |->
		(pipeline_stage_4 == expected_word(pc_stage_4[`CPU_ADDR_BITS - 1 : 1])))
		else report_mismatch("stage 4 word does not match its address");

	a_word_order: assert property (@(posedge CLK) disable iff (!RSTb)
		(post_cnt >= 1 && !nop_stage_4) |-> (pc_stage_4[`CPU_ADDR_BITS - 1 : 1] == exp_pc))
		else report_mismatch("stage 4 address out of sequence");

	a_branch_retires: assert property (@(posedge CLK) disable iff (!RSTb)
		branch_hit |-> !nop_stage_4)
		else report_mismatch("branching word missing from stage 4");

	// Execute, memory and writeback words move one slot per cycle
	a_word_shift: assert property (@(posedge CLK) disable iff (!RSTb)
		(post_cnt >= 3) |->
		(pipeline_stage_3 == $past(pipeline_stage_2) &&
		pipeline_stage_4 == $past(pipeline_stage_3)))
		else report_mismatch("instruction word not shifted through the back slots");

	// Bubble count per hazard distance
	a_stall_h1: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && hazard_1 && !load_pc_request) |=> (!wb_stb && hazard_reg1 == held_tag) [*3]
		##1 wb_stb)
		else report_mismatch("wrong stall after hazard_1");

	a_stall_h2: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && !hazard_1 && hazard_2 && !load_pc_request)
		|=> (!wb_stb && hazard_reg1 == held_tag) [*2] ##1 wb_stb)
		else report_mismatch("wrong stall after hazard_2");

	a_stall_h3: assert property (@(posedge CLK) disable iff (!RSTb)
		(wb_stb && !hazard_1 && !hazard_2 && hazard_3 && !load_pc_request)
		|=> (!wb_stb && hazard_reg1 == held_tag) ##1 wb_stb)
		else report_mismatch("wrong stall after hazard_3");

	// Tags shift one slot per cycle
	a_tag_shift: assert property (@(posedge CLK) disable iff (!RSTb)
		(post_cnt >= 3 && wb_stb) |->
		(hazard_reg2 == $past(hazard_reg1) && hazard_reg3 == $past(hazard_reg2)))
		else report_mismatch("hazard tag not shifted");

	initial begin
		logic [31:0] r;

		RSTb = 1'b0;
		load_pc_request = 1'b0;
		load_pc_address = '0;
		hazard_1 = 1'b0;
		hazard_2 = 1'b0;
		hazard_3 = 1'b0;
		hazard_reg0 = '0;
		ack_delay = 2'd0;
		lfsr_state = 32'h671;
		cyc = 0;
		post_cnt = 0;

		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		for (int i = 0; i < run_cycles; i++) begin
			@(negedge CLK);
			random_bits(2, r);
			ack_delay = r[1:0];
			random_bits(7, r);
			hazard_reg0 = r[6:0];

			// Hazards only matter while fetching, value 3 raises all three
			random_bits(4, r);
			hazard_1 = wb_stb && (r[3:0] == 4'd0 || r[3:0] == 4'd3);
			hazard_2 = wb_stb && (r[3:0] == 4'd1 || r[3:0] == 4'd3);
			hazard_3 = wb_stb && (r[3:0] == 4'd2 || r[3:0] == 4'd3);

			// Branch from a valid execute word to an even target
			random_bits(4, r);
			load_pc_request = wb_stb && !nop_stage_2 && (r[3:0] == 4'd0);
			random_bits(15, r);
			load_pc_address = {r[14:0], 1'b0};
		end

		@(negedge CLK);
		if (retired < 100)
			abort_with_reason("Too few instructions reached writeback");
		else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: build.f
+incdir+include
source/cpu_pipe_pkg.sv
source/pipeline_sequencer.sv
source/fetch_stage.sv
source/decode_slot.sv
source/back_slots.sv
source/cpu_pipeline_top.sv
verif/tb_wb_program_memory.sv
verif/tb_cpu_pipeline.sv
